//--- rtl/ppuTimingPkg.sv
package ppuTimingPkg;

   localparam int dotsPerLine   = 456;
   localparam int linesPerFrame = 154;
   localparam int visibleLines  = 144;
   localparam int oamScanEnd    = 80;   // First dot of transfer
   localparam int transferEnd   = 252;  // First dot of hblank

   typedef logic [8:0] dotT;
   typedef logic [7:0] lineT;

   // Encoding matches the STAT mode field
   typedef enum logic [1:0] {
      hblank   = 2'd0,
      vblank   = 2'd1,
      oamScan  = 2'd2,
      transfer = 2'd3
   } ppuModeT;

endpackage

//--- rtl/ppuMemPkg.sv
package ppuMemPkg;

   typedef logic [7:0]   byteT;
   typedef logic [15:0]  cpuAddrT;
   typedef logic [12:0]  vramAddrT;
   typedef logic [4:0]   tileColT;
   typedef logic [159:0] lineRowT;

   localparam cpuAddrT addrLcdc = 16'hFF40;
   localparam cpuAddrT addrStat = 16'hFF41;
   localparam cpuAddrT addrLy   = 16'hFF44;
   localparam cpuAddrT addrLyc  = 16'hFF45;
   localparam cpuAddrT addrBgp  = 16'hFF47;

   localparam cpuAddrT vramBase = 16'h8000;
   localparam cpuAddrT vramTop  = 16'h9FFF;

   localparam int lcdcEnable    = 7;
   localparam int lcdcTileData  = 4;
   localparam int lcdcMapSelect = 3;

   // STAT interrupt enables, hblank is the lowest of the four
   localparam int statLycEn    = 6;
   localparam int statOamEn    = 5;
   localparam int statVblankEn = 4;
   localparam int statHblankEn = 3;

   localparam vramAddrT mapBase0       = 13'h1800;
   localparam vramAddrT mapBase1       = 13'h1C00;
   localparam vramAddrT signedDataBase = 13'h0800;

   localparam int tilesPerLine = 20;

endpackage

//--- rtl/ppuIfs.sv
interface vramPort;
   ppuMemPkg::vramAddrT addr;
   ppuMemPkg::byteT     wrData;
   ppuMemPkg::byteT     rdData;   // Valid one cycle after rd
   logic                wr;
   logic                rd;

   modport host (output addr, output wrData, output wr, output rd, input rdData);
   modport memory (input addr, input wrData, input wr, input rd, output rdData);
endinterface

interface tileWrite;
   logic               valid;   // One-cycle strobe per tile
   ppuMemPkg::tileColT column;
   ppuMemPkg::byteT    lo;
   ppuMemPkg::byteT    hi;

   modport source (output valid, output column, output lo, output hi);
   modport sink (input valid, input column, input lo, input hi);
endinterface

//--- rtl/ppuRegisters.sv
module ppuRegisters (
   input  logic                   clock,
   input  logic                   rst,
   input  ppuMemPkg::cpuAddrT     cpuAddr,
   input  ppuMemPkg::byteT        cpuWrData,
   output ppuMemPkg::byteT        cpuRdData,
   input  logic                   cpuCs,
   input  logic                   cpuWr,
   input  logic                   cpuRd,
   input  ppuTimingPkg::ppuModeT  mode,
   input  ppuTimingPkg::lineT     ly,
   output ppuMemPkg::byteT        lcdc,
   output ppuMemPkg::byteT        lyc,
   output ppuMemPkg::byteT        bgp,
   output logic [3:0]             statEnables,
   vramPort.host                  cpuVram
);

   logic            inVram;
   logic            coincidence;
   logic            rdFromVram;
   ppuMemPkg::byteT statValue;
   ppuMemPkg::byteT regRead;
   ppuMemPkg::byteT rdHold;

   assign inVram = (cpuAddr >= ppuMemPkg::vramBase) && (cpuAddr <= ppuMemPkg::vramTop);
   assign coincidence = (ly == lyc);
   assign statValue = {1'b1, statEnables, coincidence, mode};

   // VRAM window accesses go out as offsets
   assign cpuVram.addr   = ppuMemPkg::vramAddrT'(cpuAddr - ppuMemPkg::vramBase);
   assign cpuVram.wrData = cpuWrData;
   assign cpuVram.wr     = cpuCs && cpuWr && inVram;
   assign cpuVram.rd     = cpuCs && cpuRd && inVram;

   always_ff @(posedge clock) begin
      if (rst) begin
         lcdc        <= '0;
         lyc         <= '0;
         bgp         <= '0;
         statEnables <= '0;
      end else if (cpuCs && cpuWr) begin
         case (cpuAddr)
            ppuMemPkg::addrLcdc: lcdc <= cpuWrData;
            ppuMemPkg::addrStat:
               statEnables <= cpuWrData[ppuMemPkg::statLycEn:ppuMemPkg::statHblankEn];
            ppuMemPkg::addrLyc:  lyc <= cpuWrData;
            ppuMemPkg::addrBgp:  bgp <= cpuWrData;
            default: ;            // LY is read-only
         endcase
      end
   end

   always_comb begin
      case (cpuAddr)
         ppuMemPkg::addrLcdc: regRead = lcdc;
         ppuMemPkg::addrStat: regRead = statValue;
         ppuMemPkg::addrLy:   regRead = ly;
         ppuMemPkg::addrLyc:  regRead = lyc;
         ppuMemPkg::addrBgp:  regRead = bgp;
         default:             regRead = 8'hFF;
      endcase
   end

   // Read stage, VRAM data arrives on its own one cycle later
   always_ff @(posedge clock) begin
      if (rst) begin
         rdFromVram <= 1'b0;
      end else if (cpuCs && cpuRd) begin
         rdFromVram <= inVram;
      end
   end

   always_ff @(posedge clock) begin
      if (cpuCs && cpuRd) begin
         rdHold <= regRead;
      end
   end

   assign cpuRdData = rdFromVram ? cpuVram.rdData : rdHold;

endmodule

//--- rtl/lineTimer.sv
module lineTimer (
   input  logic                   clock,
   input  logic                   rst,
   input  ppuMemPkg::byteT        lcdc,
   input  ppuMemPkg::byteT        lyc,
   input  logic [3:0]             statEnables,
   output ppuTimingPkg::ppuModeT  mode,
   output ppuTimingPkg::lineT     ly,
   output logic                   vblankIrq,
   output logic                   statIrq
);

   ppuTimingPkg::dotT dot;
   logic              enabled;
   logic              lastDot;
   logic              coincidence;

   assign enabled = lcdc[ppuMemPkg::lcdcEnable];
   assign lastDot = (dot == ppuTimingPkg::dotT'(ppuTimingPkg::dotsPerLine - 1));

   always_ff @(posedge clock) begin
      if (rst || !enabled) begin
         dot <= '0;   // Held at dot 0 of line 0 while off
         ly  <= '0;
      end else if (lastDot) begin
         dot <= '0;
         if (ly == ppuTimingPkg::lineT'(ppuTimingPkg::linesPerFrame - 1)) begin
            ly <= '0;
         end else begin
            ly <= ly + 8'd1;
         end
      end else begin
         dot <= dot + 9'd1;
      end
   end

   always_comb begin
      if (!enabled) begin
         mode = ppuTimingPkg::hblank;
      end else if (ly >= ppuTimingPkg::lineT'(ppuTimingPkg::visibleLines)) begin
         mode = ppuTimingPkg::vblank;
      end else if (dot < ppuTimingPkg::dotT'(ppuTimingPkg::oamScanEnd)) begin
         mode = ppuTimingPkg::oamScan;
      end else if (dot < ppuTimingPkg::dotT'(ppuTimingPkg::transferEnd)) begin
         mode = ppuTimingPkg::transfer;
      end else begin
         mode = ppuTimingPkg::hblank;
      end
   end

   assign coincidence = (ly == lyc);
   assign vblankIrq   = (mode == ppuTimingPkg::vblank);

   // Enables are indexed relative to the hblank enable bit
   assign statIrq =
      (statEnables[ppuMemPkg::statLycEn - ppuMemPkg::statHblankEn] && coincidence) ||
      (statEnables[ppuMemPkg::statOamEn - ppuMemPkg::statHblankEn] &&
       (mode == ppuTimingPkg::oamScan)) ||
      (statEnables[ppuMemPkg::statVblankEn - ppuMemPkg::statHblankEn] &&
       (mode == ppuTimingPkg::vblank)) ||
      (statEnables[0] && (mode == ppuTimingPkg::hblank));

   dotInRange: assert property (@(posedge clock) disable iff (rst)
      dot <= ppuTimingPkg::dotT'(ppuTimingPkg::dotsPerLine - 1));

endmodule

//--- rtl/bgFetcher.sv
module bgFetcher (
   input  logic                   clock,
   input  logic                   rst,
   input  ppuTimingPkg::ppuModeT  mode,
   input  ppuTimingPkg::lineT     ly,
   input  ppuMemPkg::byteT        lcdc,
   vramPort.host                  vram,
   tileWrite.source               tiles
);

   // Six cycles per tile, stMap doubles as the idle state's first transfer cycle
   typedef enum logic [2:0] {
      stIdle,
      stMap,
      stMapWait,
      stLo,
      stLoWait,
      stHi,
      stHiWait
   } fetchStateT;

   fetchStateT          state;
   fetchStateT          step;
   ppuMemPkg::tileColT  column;
   ppuMemPkg::byteT     tileNum;
   ppuMemPkg::byteT     loByte;
   ppuMemPkg::vramAddrT mapBase;
   logic                lineDone;
   logic                inTransfer;

   function automatic ppuMemPkg::vramAddrT dataAddr(ppuMemPkg::byteT tile, logic plane);
      ppuMemPkg::byteT biased;
      biased = tile + 8'd128;   // Signed tile number moved into 0..255
      if (lcdc[ppuMemPkg::lcdcTileData]) begin
         return ppuMemPkg::vramAddrT'({tile, ly[2:0], plane});
      end
      return ppuMemPkg::signedDataBase + ppuMemPkg::vramAddrT'({biased, ly[2:0], plane});
   endfunction

   assign inTransfer = (mode == ppuTimingPkg::transfer);
   assign step = (state == stIdle && inTransfer && !lineDone) ? stMap : state;
   assign mapBase = lcdc[ppuMemPkg::lcdcMapSelect] ? ppuMemPkg::mapBase1 : ppuMemPkg::mapBase0;

   always_comb begin
      case (step)
         stLo:             vram.addr = dataAddr(vram.rdData, 1'b0);   // Map byte just arrived
         stLoWait:         vram.addr = dataAddr(tileNum, 1'b0);
         stHi, stHiWait:   vram.addr = dataAddr(tileNum, 1'b1);
         default:          vram.addr = mapBase + ppuMemPkg::vramAddrT'({ly[7:3], column});
      endcase
   end

   assign vram.rd     = (step != stIdle);
   assign vram.wr     = 1'b0;
   assign vram.wrData = '0;

   assign tiles.valid  = (state == stHiWait);
   assign tiles.column = column;
   assign tiles.lo     = loByte;
   assign tiles.hi     = vram.rdData;

   always_ff @(posedge clock) begin
      if (rst || !inTransfer) begin
         state    <= stIdle;
         column   <= '0;
         lineDone <= 1'b0;
      end else begin
         case (step)
            stMap:     state <= stMapWait;
            stMapWait: state <= stLo;
            stLo:      state <= stLoWait;
            stLoWait:  state <= stHi;
            stHi:      state <= stHiWait;
            stHiWait: begin
               if (column == ppuMemPkg::tileColT'(ppuMemPkg::tilesPerLine - 1)) begin
                  state    <= stIdle;
                  column   <= '0;
                  lineDone <= 1'b1;   // Hold off until the next transfer
               end else begin
                  state  <= stMap;
                  column <= column + 5'd1;
               end
            end
            default:   state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (step == stLo) begin
         tileNum <= vram.rdData;
      end
      if (step == stHi) begin
         loByte <= vram.rdData;
      end
   end

   idleOutsideTransfer: assert property (@(posedge clock)
      disable iff (rst || !lcdc[ppuMemPkg::lcdcEnable])
      !inTransfer |-> state == stIdle);

endmodule

//--- rtl/vramArbiter.sv
module vramArbiter (
   input  ppuTimingPkg::ppuModeT  mode,
   vramPort.memory                cpuVram,
   vramPort.memory                fetchVram,
   output ppuMemPkg::vramAddrT    vramAddr,
   output ppuMemPkg::byteT        vramWrData,
   input  ppuMemPkg::byteT        vramRdData,
   output logic                   vramWr,
   output logic                   vramRd
);

   logic fetchOwns;

   assign fetchOwns = (mode == ppuTimingPkg::transfer);

   // CPU requests in transfer never reach the bus
   assign vramAddr   = fetchOwns ? fetchVram.addr : cpuVram.addr;
   assign vramWrData = fetchOwns ? fetchVram.wrData : cpuVram.wrData;
   assign vramWr     = fetchOwns ? fetchVram.wr : cpuVram.wr;
   assign vramRd     = fetchOwns ? fetchVram.rd : cpuVram.rd;

   assign cpuVram.rdData   = fetchOwns ? 8'hFF : vramRdData;
   assign fetchVram.rdData = vramRdData;

   // Fetcher is read-only on the shared bus
   always_comb begin
      fetchNoWrite: assert final (!fetchVram.wr);
   end

endmodule

//--- rtl/lineBuffer.sv
module lineBuffer (
   input  logic                   clock,
   input  logic                   rst,
   input  ppuTimingPkg::ppuModeT  mode,
   input  ppuMemPkg::byteT        bgp,
   tileWrite.sink                 tiles,
   output ppuMemPkg::lineRowT     linePixelsLo,
   output ppuMemPkg::lineRowT     linePixelsHi,
   output logic                   lineReady
);

   ppuTimingPkg::ppuModeT prevMode;
   logic [1:0]            shade [8];
   logic                  scanStart;

   assign scanStart = (mode == ppuTimingPkg::oamScan) && (prevMode != ppuTimingPkg::oamScan);

   // Transfer only runs on visible lines, so its end marks a finished line
   assign lineReady = (mode == ppuTimingPkg::hblank) && (prevMode == ppuTimingPkg::transfer);

   always_ff @(posedge clock) begin
      if (rst) begin
         prevMode <= ppuTimingPkg::hblank;
      end else begin
         prevMode <= mode;
      end
   end

   always_comb begin
      for (int p = 0; p < 8; p++) begin
         shade[p] = bgp[2 * {tiles.hi[7 - p], tiles.lo[7 - p]} +: 2];   // Leftmost pixel in bit 7
      end
   end

   always_ff @(posedge clock) begin
      if (scanStart) begin
         linePixelsLo <= '0;
         linePixelsHi <= '0;
      end else if (tiles.valid) begin
         for (int p = 0; p < 8; p++) begin
            linePixelsLo[8 * tiles.column + p] <= shade[p][0];
            linePixelsHi[8 * tiles.column + p] <= shade[p][1];
         end
      end
   end

endmodule

//--- rtl/ppuTop.sv
module ppuTop (
   input  logic                 clock,
   input  logic                 rst,
   input  ppuMemPkg::cpuAddrT   cpuAddr,
   input  ppuMemPkg::byteT      cpuWrData,
   output ppuMemPkg::byteT      cpuRdData,
   input  logic                 cpuCs,
   input  logic                 cpuWr,
   input  logic                 cpuRd,
   output ppuMemPkg::vramAddrT  vramAddr,
   output ppuMemPkg::byteT      vramWrData,
   input  ppuMemPkg::byteT      vramRdData,
   output logic                 vramWr,
   output logic                 vramRd,
   output logic                 vblankIrq,
   output logic                 statIrq,
   output ppuTimingPkg::lineT   ly,
   output ppuMemPkg::lineRowT   linePixelsLo,
   output ppuMemPkg::lineRowT   linePixelsHi,
   output logic                 lineReady
);

   ppuTimingPkg::ppuModeT mode;
   ppuMemPkg::byteT       lcdc;
   ppuMemPkg::byteT       lyc;
   ppuMemPkg::byteT       bgp;
   logic [3:0]            statEnables;

   vramPort  cpuVram ();
   vramPort  fetchVram ();
   tileWrite tiles ();

   ppuRegisters registers (
      .clock(clock), .rst(rst),
      .cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuRdData(cpuRdData),
      .cpuCs(cpuCs), .cpuWr(cpuWr), .cpuRd(cpuRd),
      .mode(mode), .ly(ly),
      .lcdc(lcdc), .lyc(lyc), .bgp(bgp), .statEnables(statEnables),
      .cpuVram(cpuVram.host)
   );

   lineTimer timer (
      .clock(clock), .rst(rst),
      .lcdc(lcdc), .lyc(lyc), .statEnables(statEnables),
      .mode(mode), .ly(ly),
      .vblankIrq(vblankIrq), .statIrq(statIrq)
   );

   bgFetcher fetcher (
      .clock(clock), .rst(rst),
      .mode(mode), .ly(ly), .lcdc(lcdc),
      .vram(fetchVram.host), .tiles(tiles.source)
   );

   vramArbiter arbiter (
      .mode(mode),
      .cpuVram(cpuVram.memory), .fetchVram(fetchVram.memory),
      .vramAddr(vramAddr), .vramWrData(vramWrData), .vramRdData(vramRdData),
      .vramWr(vramWr), .vramRd(vramRd)
   );

   lineBuffer buffer (
      .clock(clock), .rst(rst),
      .mode(mode), .bgp(bgp), .tiles(tiles.sink),
      .linePixelsLo(linePixelsLo), .linePixelsHi(linePixelsHi),
      .lineReady(lineReady)
   );

endmodule

//--- verif/ppuTb.sv
module ppuTb;

   localparam int frameCycles  = ppuTimingPkg::dotsPerLine * ppuTimingPkg::linesPerFrame;
   localparam int watchdogTime = frameCycles * 33;   // Three frames at period 10 plus 10% margin

   logic                  clock, rst;
   ppuMemPkg::cpuAddrT    cpuAddr;
   ppuMemPkg::byteT       cpuWrData, cpuRdData;
   logic                  cpuCs, cpuWr, cpuRd;
   ppuMemPkg::vramAddrT   vramAddr;
   ppuMemPkg::byteT       vramWrData;
   ppuMemPkg::byteT       vramRdData = '0;
   logic                  vramWr, vramRd, vblankIrq, statIrq, lineReady;
   ppuTimingPkg::lineT    ly;
   ppuMemPkg::lineRowT    linePixelsLo, linePixelsHi;

   ppuMemPkg::byteT vram [8192];
   logic            fillReq;
   logic [31:0]     fillKey;
   logic            refOn;
   int              refDot, refLine;
   int              errors;

   ppuTop uut (.*);

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   // VRAM model with one-cycle read latency
   always @(posedge clock) begin
      if (fillReq) begin
         for (int i = 0; i < 8192; i++) begin
            vram[i] <= ppuMemPkg::byteT'(((i * 32'h9E3779B1) ^ fillKey) >> 13);
         end
      end else if (vramWr) begin
         vram[vramAddr] <= vramWrData;
      end
      if (vramRd) begin
         vramRdData <= vram[vramAddr];
      end
   end

   // Expected dot and line position
   always @(posedge clock) begin
      if (rst || !refOn) begin
         refDot  <= 0;
         refLine <= 0;
      end else if (refDot == ppuTimingPkg::dotsPerLine - 1) begin
         refDot  <= 0;
         refLine <= (refLine + 1) % ppuTimingPkg::linesPerFrame;
      end else begin
         refDot <= refDot + 1;
      end
      if (rst) begin
         refOn <= 1'b0;
      end else if (cpuCs && cpuWr && cpuAddr == ppuMemPkg::addrLcdc) begin
         refOn <= cpuWrData[ppuMemPkg::lcdcEnable];
      end
   end

   initial begin
      #(watchdogTime);
      $display("Watchdog expired before the tests finished, %0d errors so far", errors);
      $display("Done: errors found");
      $finish;
   end

   task automatic checkByte(input string name, input ppuMemPkg::byteT got, exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkLine(input string name, input ppuTimingPkg::lineT got, exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkMode(input string name, input ppuTimingPkg::ppuModeT got, exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkRow(input string name, input ppuMemPkg::lineRowT got, exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic cpuWrite(input ppuMemPkg::cpuAddrT addr, input ppuMemPkg::byteT data);
      cpuAddr   = addr;
      cpuWrData = data;
      cpuCs     = 1'b1;
      cpuWr     = 1'b1;
      @(negedge clock);
      cpuCs = 1'b0;
      cpuWr = 1'b0;
   endtask

   task automatic cpuRead(input ppuMemPkg::cpuAddrT addr, output ppuMemPkg::byteT data);
      cpuAddr = addr;
      cpuCs   = 1'b1;
      cpuRd   = 1'b1;
      @(negedge clock);
      data  = cpuRdData;   // One cycle after the strobe
      cpuCs = 1'b0;
      cpuRd = 1'b0;
   endtask

   task automatic waitDot(input int line, input int dot);
      while (refLine != line || refDot != dot) begin
         @(negedge clock);
      end
   endtask

   function automatic ppuTimingPkg::ppuModeT expectedMode(input int line, input int dot);
      if (line >= ppuTimingPkg::visibleLines) return ppuTimingPkg::vblank;
      if (dot < ppuTimingPkg::oamScanEnd) return ppuTimingPkg::oamScan;
      if (dot < ppuTimingPkg::transferEnd) return ppuTimingPkg::transfer;
      return ppuTimingPkg::hblank;
   endfunction

   task automatic renderExpected(input int line, input ppuMemPkg::byteT lcdcVal, pal,
                                 output ppuMemPkg::lineRowT lo, hi);
      int              mapAddr, tile, dataAddr, shade;
      ppuMemPkg::byteT loByte, hiByte;
      for (int c = 0; c < ppuMemPkg::tilesPerLine; c++) begin
         mapAddr = lcdcVal[ppuMemPkg::lcdcMapSelect] ? ppuMemPkg::mapBase1 : ppuMemPkg::mapBase0;
         tile    = vram[mapAddr + 32 * (line / 8) + c];
         if (lcdcVal[ppuMemPkg::lcdcTileData]) begin
            dataAddr = tile * 16 + 2 * (line % 8);
         end else begin
            dataAddr = ppuMemPkg::signedDataBase + ((tile + 128) % 256) * 16 + 2 * (line % 8);
         end
         loByte = vram[dataAddr];
         hiByte = vram[dataAddr + 1];
         for (int p = 0; p < 8; p++) begin
            shade = (pal >> (2 * (2 * hiByte[7 - p] + loByte[7 - p]))) & 3;
            lo[8 * c + p] = shade[0];
            hi[8 * c + p] = shade[1];
         end
      end
   endtask

   task automatic resetLevels();
      checkFlag("vblankIrq after reset", vblankIrq, 1'b0);
      checkFlag("statIrq after reset", statIrq, 1'b0);
      checkFlag("lineReady after reset", lineReady, 1'b0);
      checkFlag("vramWr after reset", vramWr, 1'b0);
      checkFlag("vramRd after reset", vramRd, 1'b0);
   endtask

   task automatic registerAccess();
      ppuMemPkg::byteT lcdcVal, lycVal, bgpVal, value;
      lcdcVal = ppuMemPkg::byteT'($urandom) & 8'h7F;   // Display stays off
      lycVal  = ppuMemPkg::byteT'($urandom);
      bgpVal  = ppuMemPkg::byteT'($urandom);
      cpuWrite(ppuMemPkg::addrLcdc, lcdcVal);
      cpuWrite(ppuMemPkg::addrLyc, lycVal);
      cpuWrite(ppuMemPkg::addrBgp, bgpVal);
      cpuWrite(ppuMemPkg::addrStat, 8'h78);
      cpuWrite(ppuMemPkg::addrLy, 8'h55);
      cpuRead(ppuMemPkg::addrLcdc, value);
      checkByte("LCDC", value, lcdcVal);
      cpuRead(ppuMemPkg::addrLyc, value);
      checkByte("LYC", value, lycVal);
      cpuRead(ppuMemPkg::addrBgp, value);
      checkByte("BGP", value, bgpVal);
      cpuRead(ppuMemPkg::addrStat, value);
      checkByte("STAT", value, {1'b1, 4'b1111, lycVal == 8'd0, 2'b00});
      cpuRead(ppuMemPkg::addrLy, value);
      checkLine("LY", value, 8'd0);
      cpuWrite(ppuMemPkg::addrStat, 8'h00);
      cpuWrite(ppuMemPkg::addrLcdc, 8'h00);
   endtask

   task automatic lineTiming();
      ppuMemPkg::byteT value;
      int              dots [3];
      int              line;
      dots = '{10, 100, 300};
      cpuWrite(ppuMemPkg::addrLcdc, 8'h80);
      foreach (dots[i]) begin
         waitDot(0, dots[i]);
         cpuRead(ppuMemPkg::addrStat, value);
         checkMode("STAT mode", ppuTimingPkg::ppuModeT'(value[1:0]), expectedMode(0, dots[i]));
      end
      for (int n = 1; n <= ppuTimingPkg::linesPerFrame; n++) begin
         line = n % ppuTimingPkg::linesPerFrame;   // Last read lands after the wrap
         waitDot(line, 200);
         cpuRead(ppuMemPkg::addrLy, value);
         checkLine("LY", value, ppuTimingPkg::lineT'(line));
      end
      waitDot(1, 100);   // Away from line 0 so the clear shows
      cpuWrite(ppuMemPkg::addrLcdc, 8'h00);
      waitDot(0, 0);
      cpuRead(ppuMemPkg::addrLy, value);
      checkLine("LY after disable", value, 8'd0);
      checkLine("ly", ly, 8'd0);
   endtask

   task automatic backgroundRender();
      ppuMemPkg::byteT    bgpVal, lcdcVal;
      ppuMemPkg::lineRowT expLo, expHi;
      int                 line;
      bgpVal  = ppuMemPkg::byteT'($urandom);
      fillKey = $urandom;
      fillReq = 1'b1;
      @(negedge clock);
      fillReq = 1'b0;
      cpuWrite(ppuMemPkg::addrBgp, bgpVal);
      cpuWrite(ppuMemPkg::addrLcdc, 8'h80);
      for (int combo = 0; combo < 4; combo++) begin
         line    = 7 + combo;   // Crosses from map row 0 into row 1
         lcdcVal = 8'h80;
         lcdcVal[ppuMemPkg::lcdcMapSelect] = combo[1];
         lcdcVal[ppuMemPkg::lcdcTileData]  = combo[0];
         waitDot(line - 1, 300);
         cpuWrite(ppuMemPkg::addrLcdc, lcdcVal);
         while (!lineReady) begin
            @(negedge clock);
         end
         renderExpected(line, lcdcVal, bgpVal, expLo, expHi);
         checkLine("ly at lineReady", ly, ppuTimingPkg::lineT'(line));
         checkRow("linePixelsLo", linePixelsLo, expLo);
         checkRow("linePixelsHi", linePixelsHi, expHi);
      end
   endtask

   task automatic vramArbitration();
      ppuMemPkg::byteT keep, wrVal, value;
      keep  = vram[13'h0123];
      wrVal = vram[13'h1A55] ^ (ppuMemPkg::byteT'($urandom) | 8'h01);   // Always a new value
      waitDot(11, 150);
      cpuRead(16'h8123, value);
      checkByte("VRAM read in transfer", value, 8'hFF);
      waitDot(11, 160);
      cpuWrite(16'h8123, ~keep);   // Dropped by the arbiter
      waitDot(145, 10);
      cpuWrite(16'h9A55, wrVal);
      cpuRead(16'h9A55, value);
      checkByte("VRAM readback in vblank", value, wrVal);
      cpuRead(16'h8123, value);
      checkByte("VRAM after write in transfer", value, keep);
   endtask

   task automatic interruptLevels();
      ppuMemPkg::byteT lycVal;
      logic            prevIrq;
      lycVal = ppuMemPkg::byteT'(1 + $urandom % 143);
      cpuWrite(ppuMemPkg::addrLyc, lycVal);
      cpuWrite(ppuMemPkg::addrStat, ppuMemPkg::byteT'(1 << ppuMemPkg::statLycEn));
      for (int n = 0; n < frameCycles; n++) begin
         checkFlag("vblankIrq", vblankIrq, refLine >= ppuTimingPkg::visibleLines);
         checkFlag("statIrq", statIrq, refLine == lycVal);
         checkLine("ly", ly, ppuTimingPkg::lineT'(refLine));
         @(negedge clock);
      end
      cpuWrite(ppuMemPkg::addrStat, ppuMemPkg::byteT'(1 << ppuMemPkg::statHblankEn));
      prevIrq = statIrq;
      while (!lineReady) begin
         prevIrq = statIrq;
         @(negedge clock);
      end
      checkFlag("statIrq before hblank", prevIrq, 1'b0);
      checkFlag("statIrq at lineReady", statIrq, 1'b1);
      @(negedge clock);
      checkFlag("lineReady after pulse", lineReady, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h93603ec9));
      errors    = 0;
      rst       = 1'b1;
      cpuAddr   = '0;
      cpuWrData = '0;
      cpuCs     = 1'b0;
      cpuWr     = 1'b0;
      cpuRd     = 1'b0;
      fillReq   = 1'b0;
      fillKey   = '0;
      repeat (2) @(negedge clock);
      rst = 1'b0;
      resetLevels();
      registerAccess();
      lineTiming();
      backgroundRender();
      vramArbitration();
      interruptLevels();
      $display("Tests finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- project.f
rtl/ppuTimingPkg.sv
rtl/ppuMemPkg.sv
rtl/ppuIfs.sv
rtl/ppuRegisters.sv
rtl/lineTimer.sv
rtl/bgFetcher.sv
rtl/vramArbiter.sv
rtl/lineBuffer.sv
rtl/ppuTop.sv
verif/ppuTb.sv
